// File: radio_pkg.sv
//////////////////////////////////////////////////
// Shared widths, register map and response codes
// NUM_RADIOS must stay below 256 (8-bit index field)
//////////////////////////////////////////////////
package radio_pkg;

  localparam int NUM_RADIOS  = 2;
  // Port 0 is front-end control
  localparam int NUM_PORTS   = NUM_RADIOS + 1;
  localparam int RADIO_IDX_W = (NUM_RADIOS > 1) ? $clog2(NUM_RADIOS) : 1;
  localparam int SAMPLE_W    = 32;
  localparam int RB_W        = 64;

  typedef logic [7:0]             set_addr_t;
  typedef logic [31:0]            set_data_t;
  typedef logic [RB_W-1:0]        rb_data_t;
  typedef logic [63:0]            vita_time_t;
  // 16-bit I in the upper half, 16-bit Q in the lower
  typedef logic [SAMPLE_W-1:0]    sample_t;
  // Radio index, code, then low 48 bits of VITA time
  typedef logic [63:0]            resp_t;
  typedef logic [7:0]             resp_code_t;
  typedef logic [1:0]             rb_sel_t;
  typedef logic [31:0]            samp_cnt_t;
  typedef logic [RADIO_IDX_W-1:0] radio_idx_t;

  //////////////////////////////////////////////////
  // Settings register map
  //////////////////////////////////////////////////
  localparam set_addr_t SR_TIME_HI        = 8'd128;
  localparam set_addr_t SR_TIME_LO        = 8'd129;
  // Bit 0 loads now, bit 1 loads at next PPS
  localparam set_addr_t SR_TIME_CTRL      = 8'd130;
  localparam set_addr_t SR_RX_NUM_SAMPS   = 8'd131;
  localparam set_addr_t SR_RX_CMD_TIME_HI = 8'd132;
  localparam set_addr_t SR_RX_CMD_TIME_LO = 8'd133;
  // Bit 0 marks a timed command
  localparam set_addr_t SR_RX_CMD         = 8'd134;
  localparam set_addr_t SR_TX_CTRL        = 8'd135;
  localparam set_addr_t SR_RB_SEL         = 8'd136;
  localparam set_addr_t SR_FE_READBACK    = 8'd255;

  // Readback selects
  localparam rb_sel_t RB_VITA_TIME    = 2'd0;
  localparam rb_sel_t RB_VITA_LASTPPS = 2'd1;
  localparam rb_sel_t RB_RX_STATUS    = 2'd2;
  localparam rb_sel_t RB_RADIO_ID     = 2'd3;

  // Response codes
  localparam resp_code_t RESP_OVERRUN  = 8'd1;
  localparam resp_code_t RESP_LATE_CMD = 8'd2;
  localparam resp_code_t RESP_UNDERRUN = 8'd3;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_WAIT_TIME,
    RX_RUN
  } rx_state_t;

endpackage

// File: settings_if.sv
//////////////////////////////////////////////////
// One block port of the settings bus
// A write is any cycle with stb high, rb_data is a level
//////////////////////////////////////////////////
`timescale 1ns/1ps

interface settings_if;
  import radio_pkg::*;

  logic      stb;
  set_addr_t addr;
  set_data_t data;
  rb_data_t  rb_data;

  modport master (
    output stb,
    output addr,
    output data,
    input  rb_data
  );

  modport slave (
    input  stb,
    input  addr,
    input  data,
    output rb_data
  );

endinterface

// File: timekeeper.sv
//////////////////////////////////////////////////
// VITA time counter, i_pps must be synchronous to i_ce_clk
// A PPS load stays armed until the next rising edge
//////////////////////////////////////////////////
`timescale 1ns/1ps

module timekeeper (
  input  logic                  i_ce_clk,
  input  logic                  i_arst_n,
  input  logic                  i_pps,
  input  logic                  i_set_stb,
  input  radio_pkg::set_addr_t  i_set_addr,
  input  radio_pkg::set_data_t  i_set_data,
  output radio_pkg::vita_time_t o_vita_time,
  output radio_pkg::vita_time_t o_vita_time_lastpps
);
  import radio_pkg::*;

  set_data_t time_hi;
  set_data_t time_lo;
  logic      pps_del;
  logic      pps_edge;
  logic      load_armed;
  logic      ctrl_wr;

  assign ctrl_wr  = i_set_stb && (i_set_addr == SR_TIME_CTRL);
  assign pps_edge = i_pps & ~pps_del;

  // Staged time value
  always_ff @(posedge i_ce_clk) begin
    if (i_set_stb && (i_set_addr == SR_TIME_HI)) begin
      time_hi <= i_set_data;
    end
    if (i_set_stb && (i_set_addr == SR_TIME_LO)) begin
      time_lo <= i_set_data;
    end
  end

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pps_del             <= 1'b0;
      load_armed          <= 1'b0;
      o_vita_time         <= '0;
      o_vita_time_lastpps <= '0;
    end else begin
      pps_del <= i_pps;
      if (ctrl_wr && i_set_data[0]) begin
        o_vita_time <= {time_hi, time_lo};
      end else if (load_armed && pps_edge) begin
        o_vita_time <= {time_hi, time_lo};
      end else begin
        o_vita_time <= o_vita_time + 64'd1;
      end
      // Time seen at the edge, before any load
      if (pps_edge) begin
        o_vita_time_lastpps <= o_vita_time;
      end
      if (ctrl_wr) begin
        load_armed <= i_set_data[1];
      end else if (pps_edge) begin
        load_armed <= 1'b0;
      end
    end
  end

endmodule

// File: radio_rx_ctrl.sv
//////////////////////////////////////////////////
// Receive sequencer, the sample count must be nonzero
// Commands are taken only while idle
//////////////////////////////////////////////////
`timescale 1ns/1ps

module radio_rx_ctrl (
  input  logic                  i_ce_clk,
  input  logic                  i_arst_n,
  input  radio_pkg::vita_time_t i_vita_time,
  input  radio_pkg::samp_cnt_t  i_num_samps,
  input  radio_pkg::vita_time_t i_cmd_time,
  input  logic                  i_cmd_stb,
  input  logic                  i_cmd_timed,
  input  radio_pkg::sample_t    i_rx,
  input  logic                  i_rx_stb,
  output logic                  o_run_rx,
  output radio_pkg::sample_t    o_rx_tdata,
  output logic                  o_rx_tlast,
  output logic                  o_rx_tvalid,
  input  logic                  i_rx_tready,
  output radio_pkg::samp_cnt_t  o_samps_left,
  output logic                  o_overrun,
  output logic                  o_late
);
  import radio_pkg::*;

  rx_state_t state;
  logic      word_stuck;
  logic      last_samp;

  // Held word not taken this cycle
  assign word_stuck = o_rx_tvalid & ~i_rx_tready;
  assign last_samp  = (o_samps_left == 32'd1);
  assign o_run_rx   = (state == RX_RUN);

  always_ff @(posedge i_ce_clk) begin
    if ((state == RX_RUN) && i_rx_stb && !word_stuck) begin
      o_rx_tdata <= i_rx;
    end
  end

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state        <= RX_IDLE;
      o_samps_left <= '0;
      o_rx_tvalid  <= 1'b0;
      o_rx_tlast   <= 1'b0;
      o_overrun    <= 1'b0;
      o_late       <= 1'b0;
    end else begin
      o_overrun <= 1'b0;
      o_late    <= 1'b0;
      if (o_rx_tvalid && i_rx_tready) begin
        o_rx_tvalid <= 1'b0;
      end
      case (state)
        RX_IDLE: begin
          if (i_cmd_stb) begin
            o_samps_left <= i_num_samps;
            if (!i_cmd_timed) begin
              state <= RX_RUN;
            end else if (i_cmd_time < i_vita_time) begin
              o_late <= 1'b1;
            end else begin
              state <= RX_WAIT_TIME;
            end
          end
        end
        RX_WAIT_TIME: begin
          if (i_vita_time >= i_cmd_time) begin
            state <= RX_RUN;
          end
        end
        RX_RUN: begin
          if (i_rx_stb) begin
            if (word_stuck) begin
              // Overrun drops the waiting word and ends the run
              o_rx_tvalid <= 1'b0;
              o_overrun   <= 1'b1;
              state       <= RX_IDLE;
            end else begin
              o_rx_tvalid  <= 1'b1;
              o_rx_tlast   <= last_samp;
              o_samps_left <= o_samps_left - 32'd1;
              if (last_samp) begin
                state <= RX_IDLE;
              end
            end
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

// File: radio_core.sv
//////////////////////////////////////////////////
// One radio: registers, readback, receive and transmit
// Only one response is held, later events are lost
//////////////////////////////////////////////////
`timescale 1ns/1ps

module radio_core #(
  parameter int RADIO_INDEX = 0
) (
  input  logic                  i_ce_clk,
  input  logic                  i_arst_n,
  settings_if.slave             settings,
  input  radio_pkg::vita_time_t i_vita_time,
  input  radio_pkg::vita_time_t i_vita_time_lastpps,
  input  radio_pkg::sample_t    i_rx,
  input  logic                  i_rx_stb,
  output logic                  o_run_rx,
  output radio_pkg::sample_t    o_rx_tdata,
  output logic                  o_rx_tlast,
  output logic                  o_rx_tvalid,
  input  logic                  i_rx_tready,
  input  radio_pkg::sample_t    i_tx_tdata,
  input  logic                  i_tx_tvalid,
  output logic                  o_tx_tready,
  input  logic                  i_tx_stb,
  output radio_pkg::sample_t    o_tx,
  output logic                  o_run_tx,
  output radio_pkg::resp_t      o_resp_tdata,
  output logic                  o_resp_tvalid,
  input  logic                  i_resp_tready
);
  import radio_pkg::*;

  samp_cnt_t  num_samps;
  samp_cnt_t  samps_left;
  set_data_t  cmd_time_hi;
  set_data_t  cmd_time_lo;
  rb_sel_t    rb_sel;
  logic       tx_en;
  logic       cmd_stb;
  logic       overrun;
  logic       late;
  logic       underrun;
  logic       any_event;
  resp_code_t event_code;

  assign cmd_stb = settings.stb && (settings.addr == SR_RX_CMD);

  always_ff @(posedge i_ce_clk) begin
    if (settings.stb) begin
      case (settings.addr)
        SR_RX_NUM_SAMPS:   num_samps   <= settings.data;
        SR_RX_CMD_TIME_HI: cmd_time_hi <= settings.data;
        SR_RX_CMD_TIME_LO: cmd_time_lo <= settings.data;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (rb_sel)
      RB_VITA_TIME:    settings.rb_data = i_vita_time;
      RB_VITA_LASTPPS: settings.rb_data = i_vita_time_lastpps;
      RB_RX_STATUS:    settings.rb_data = {31'd0, o_run_rx, samps_left};
      default:         settings.rb_data = rb_data_t'(RADIO_INDEX);
    endcase
  end

  radio_rx_ctrl i_rx_ctrl (
    .i_ce_clk     (i_ce_clk),
    .i_arst_n     (i_arst_n),
    .i_vita_time  (i_vita_time),
    .i_num_samps  (num_samps),
    .i_cmd_time   ({cmd_time_hi, cmd_time_lo}),
    .i_cmd_stb    (cmd_stb),
    .i_cmd_timed  (settings.data[0]),
    .i_rx         (i_rx),
    .i_rx_stb     (i_rx_stb),
    .o_run_rx     (o_run_rx),
    .o_rx_tdata   (o_rx_tdata),
    .o_rx_tlast   (o_rx_tlast),
    .o_rx_tvalid  (o_rx_tvalid),
    .i_rx_tready  (i_rx_tready),
    .o_samps_left (samps_left),
    .o_overrun    (overrun),
    .o_late       (late)
  );

  //////////////////////////////////////////////////
  // Transmit playback
  //////////////////////////////////////////////////
  assign o_run_tx    = tx_en;
  assign o_tx_tready = tx_en & i_tx_stb;

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      tx_en    <= 1'b0;
      rb_sel   <= RB_VITA_TIME;
      o_tx     <= '0;
      underrun <= 1'b0;
    end else begin
      underrun <= 1'b0;
      if (settings.stb && (settings.addr == SR_RB_SEL)) begin
        rb_sel <= settings.data[1:0];
      end
      if (o_tx_tready && i_tx_tvalid) begin
        o_tx <= i_tx_tdata;
      end else if (o_tx_tready) begin
        // Starved strobe stops playback
        o_tx     <= '0;
        underrun <= 1'b1;
        tx_en    <= 1'b0;
      end
      if (settings.stb && (settings.addr == SR_TX_CTRL)) begin
        tx_en <= settings.data[0];
      end
    end
  end

  //////////////////////////////////////////////////
  // Response word
  //////////////////////////////////////////////////
  assign any_event  = overrun | late | underrun;
  assign event_code = overrun ? RESP_OVERRUN : (late ? RESP_LATE_CMD : RESP_UNDERRUN);

  always_ff @(posedge i_ce_clk) begin
    if (!o_resp_tvalid && any_event) begin
      o_resp_tdata <= {8'(RADIO_INDEX), event_code, i_vita_time[47:0]};
    end
  end

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_resp_tvalid <= 1'b0;
    end else if (o_resp_tvalid) begin
      if (i_resp_tready) begin
        o_resp_tvalid <= 1'b0;
      end
    end else if (any_event) begin
      o_resp_tvalid <= 1'b1;
    end
  end

endmodule

// File: resp_mux.sv
//////////////////////////////////////////////////
// Round-robin response merge into one output register
//////////////////////////////////////////////////
`timescale 1ns/1ps

module resp_mux (
  input  logic                             i_ce_clk,
  input  logic                             i_arst_n,
  input  radio_pkg::resp_t                 i_resp_tdata [radio_pkg::NUM_RADIOS],
  input  logic [radio_pkg::NUM_RADIOS-1:0] i_resp_tvalid,
  output logic [radio_pkg::NUM_RADIOS-1:0] o_resp_tready,
  output radio_pkg::resp_t                 o_resp_tdata,
  output logic                             o_resp_tvalid,
  input  logic                             i_resp_tready
);
  import radio_pkg::*;

  radio_idx_t last_served;
  radio_idx_t grant;
  logic       found;
  logic       slot_free;

  // Output slot empties this cycle or is already empty
  assign slot_free = ~o_resp_tvalid | i_resp_tready;

  // Search starts at the radio after the last one served
  always_comb begin
    int idx;
    found = 1'b0;
    grant = last_served;
    for (int k = 1; k <= NUM_RADIOS; k++) begin
      idx = (int'(last_served) + k) % NUM_RADIOS;
      if (!found && i_resp_tvalid[idx]) begin
        found = 1'b1;
        grant = radio_idx_t'(idx);
      end
    end
  end

  always_comb begin
    o_resp_tready = '0;
    if (found && slot_free) begin
      o_resp_tready[grant] = 1'b1;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (found && slot_free) begin
      o_resp_tdata <= i_resp_tdata[grant];
    end
  end

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_resp_tvalid <= 1'b0;
      last_served   <= '0;
    end else if (found && slot_free) begin
      o_resp_tvalid <= 1'b1;
      last_served   <= grant;
    end else if (i_resp_tready) begin
      o_resp_tvalid <= 1'b0;
    end
  end

endmodule

// File: radio_block.sv
//////////////////////////////////////////////////
// Radio block top, all logic on i_ce_clk
// Port 0 is front-end control, ports 1..N are radios
//////////////////////////////////////////////////
`timescale 1ns/1ps

module radio_block (
  input  logic                                               i_ce_clk,
  input  logic                                               i_arst_n,
  input  logic [radio_pkg::NUM_PORTS-1:0]                    i_set_stb,
  input  radio_pkg::set_addr_t                               i_set_addr,
  input  radio_pkg::set_data_t                               i_set_data,
  output logic [radio_pkg::NUM_PORTS*radio_pkg::RB_W-1:0]    o_rb_data,
  input  logic                                               i_pps,
  output radio_pkg::vita_time_t                              o_vita_time,
  input  logic [radio_pkg::NUM_RADIOS*radio_pkg::SAMPLE_W-1:0] i_rx,
  input  logic                                               i_rx_stb,
  output logic [radio_pkg::NUM_RADIOS*radio_pkg::SAMPLE_W-1:0] o_tx,
  input  logic                                               i_tx_stb,
  output logic [radio_pkg::NUM_RADIOS-1:0]                   o_run_rx,
  output logic [radio_pkg::NUM_RADIOS-1:0]                   o_run_tx,
  output logic [radio_pkg::NUM_RADIOS*radio_pkg::SAMPLE_W-1:0] o_rx_tdata,
  output logic [radio_pkg::NUM_RADIOS-1:0]                   o_rx_tlast,
  output logic [radio_pkg::NUM_RADIOS-1:0]                   o_rx_tvalid,
  input  logic [radio_pkg::NUM_RADIOS-1:0]                   i_rx_tready,
  input  logic [radio_pkg::NUM_RADIOS*radio_pkg::SAMPLE_W-1:0] i_tx_tdata,
  input  logic [radio_pkg::NUM_RADIOS-1:0]                   i_tx_tvalid,
  output logic [radio_pkg::NUM_RADIOS-1:0]                   o_tx_tready,
  output radio_pkg::resp_t                                   o_resp_tdata,
  output logic                                               o_resp_tvalid,
  input  logic                                               i_resp_tready,
  output logic                                               o_fe_set_stb,
  output radio_pkg::set_addr_t                               o_fe_set_addr,
  output radio_pkg::set_data_t                               o_fe_set_data,
  output radio_pkg::set_addr_t                               o_fe_rb_addr,
  input  radio_pkg::rb_data_t                                i_fe_rb_data
);
  import radio_pkg::*;

  vita_time_t               vita_time_lastpps;
  resp_t                    resp_tdata [NUM_RADIOS];
  logic [NUM_RADIOS-1:0]    resp_tvalid;
  logic [NUM_RADIOS-1:0]    resp_tready;

  //////////////////////////////////////////////////
  // Front-end control port
  //////////////////////////////////////////////////
  assign o_fe_set_stb       = i_set_stb[0];
  assign o_fe_set_addr      = i_set_addr;
  assign o_fe_set_data      = i_set_data;
  assign o_rb_data[RB_W-1:0] = i_fe_rb_data;

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_fe_rb_addr <= '0;
    end else if (i_set_stb[0] && (i_set_addr == SR_FE_READBACK)) begin
      o_fe_rb_addr <= i_set_data[7:0];
    end
  end

  // Any radio port may set the time
  timekeeper i_timekeeper (
    .i_ce_clk            (i_ce_clk),
    .i_arst_n            (i_arst_n),
    .i_pps               (i_pps),
    .i_set_stb           (|i_set_stb[NUM_PORTS-1:1]),
    .i_set_addr          (i_set_addr),
    .i_set_data          (i_set_data),
    .o_vita_time         (o_vita_time),
    .o_vita_time_lastpps (vita_time_lastpps)
  );

  for (genvar i = 0; i < NUM_RADIOS; i++) begin : gen_radio
    settings_if set_bus ();

    assign set_bus.stb  = i_set_stb[i+1];
    assign set_bus.addr = i_set_addr;
    assign set_bus.data = i_set_data;
    assign o_rb_data[RB_W*(i+1) +: RB_W] = set_bus.rb_data;

    radio_core #(
      .RADIO_INDEX (i)
    ) i_radio_core (
      .i_ce_clk            (i_ce_clk),
      .i_arst_n            (i_arst_n),
      .settings            (set_bus.slave),
      .i_vita_time         (o_vita_time),
      .i_vita_time_lastpps (vita_time_lastpps),
      .i_rx                (i_rx[SAMPLE_W*i +: SAMPLE_W]),
      .i_rx_stb            (i_rx_stb),
      .o_run_rx            (o_run_rx[i]),
      .o_rx_tdata          (o_rx_tdata[SAMPLE_W*i +: SAMPLE_W]),
      .o_rx_tlast          (o_rx_tlast[i]),
      .o_rx_tvalid         (o_rx_tvalid[i]),
      .i_rx_tready         (i_rx_tready[i]),
      .i_tx_tdata          (i_tx_tdata[SAMPLE_W*i +: SAMPLE_W]),
      .i_tx_tvalid         (i_tx_tvalid[i]),
      .o_tx_tready         (o_tx_tready[i]),
      .i_tx_stb            (i_tx_stb),
      .o_tx                (o_tx[SAMPLE_W*i +: SAMPLE_W]),
      .o_run_tx            (o_run_tx[i]),
      .o_resp_tdata        (resp_tdata[i]),
      .o_resp_tvalid       (resp_tvalid[i]),
      .i_resp_tready       (resp_tready[i])
    );
  end

  resp_mux i_resp_mux (
    .i_ce_clk      (i_ce_clk),
    .i_arst_n      (i_arst_n),
    .i_resp_tdata  (resp_tdata),
    .i_resp_tvalid (resp_tvalid),
    .o_resp_tready (resp_tready),
    .o_resp_tdata  (o_resp_tdata),
    .o_resp_tvalid (o_resp_tvalid),
    .i_resp_tready (i_resp_tready)
  );

endmodule

// File: tb_radio_block.sv
//////////////////////////////////////////////////
// Directed testbench for the radio block
// Inputs change and outputs are sampled on the falling edge
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_radio_block;
  import radio_pkg::*;

  logic                             i_ce_clk = 1'b0;
  logic                             i_arst_n;
  logic [NUM_PORTS-1:0]             i_set_stb;
  set_addr_t                        i_set_addr;
  set_data_t                        i_set_data;
  logic [NUM_PORTS*RB_W-1:0]        o_rb_data;
  logic                             i_pps;
  vita_time_t                       o_vita_time;
  logic [NUM_RADIOS*SAMPLE_W-1:0]   i_rx;
  logic                             i_rx_stb;
  logic [NUM_RADIOS*SAMPLE_W-1:0]   o_tx;
  logic                             i_tx_stb;
  logic [NUM_RADIOS-1:0]            o_run_rx;
  logic [NUM_RADIOS-1:0]            o_run_tx;
  logic [NUM_RADIOS*SAMPLE_W-1:0]   o_rx_tdata;
  logic [NUM_RADIOS-1:0]            o_rx_tlast;
  logic [NUM_RADIOS-1:0]            o_rx_tvalid;
  logic [NUM_RADIOS-1:0]            i_rx_tready;
  logic [NUM_RADIOS*SAMPLE_W-1:0]   i_tx_tdata;
  logic [NUM_RADIOS-1:0]            i_tx_tvalid;
  logic [NUM_RADIOS-1:0]            o_tx_tready;
  resp_t                            o_resp_tdata;
  logic                             o_resp_tvalid;
  logic                             i_resp_tready;
  logic                             o_fe_set_stb;
  set_addr_t                        o_fe_set_addr;
  set_data_t                        o_fe_set_data;
  set_addr_t                        o_fe_rb_addr;
  rb_data_t                         i_fe_rb_data;

  logic [31:0] lcg_state = 32'h05d4bdad;
  int          cycle_cnt = 0;

  radio_block i_radio_block (
    .i_ce_clk      (i_ce_clk),
    .i_arst_n      (i_arst_n),
    .i_set_stb     (i_set_stb),
    .i_set_addr    (i_set_addr),
    .i_set_data    (i_set_data),
    .o_rb_data     (o_rb_data),
    .i_pps         (i_pps),
    .o_vita_time   (o_vita_time),
    .i_rx          (i_rx),
    .i_rx_stb      (i_rx_stb),
    .o_tx          (o_tx),
    .i_tx_stb      (i_tx_stb),
    .o_run_rx      (o_run_rx),
    .o_run_tx      (o_run_tx),
    .o_rx_tdata    (o_rx_tdata),
    .o_rx_tlast    (o_rx_tlast),
    .o_rx_tvalid   (o_rx_tvalid),
    .i_rx_tready   (i_rx_tready),
    .i_tx_tdata    (i_tx_tdata),
    .i_tx_tvalid   (i_tx_tvalid),
    .o_tx_tready   (o_tx_tready),
    .o_resp_tdata  (o_resp_tdata),
    .o_resp_tvalid (o_resp_tvalid),
    .i_resp_tready (i_resp_tready),
    .o_fe_set_stb  (o_fe_set_stb),
    .o_fe_set_addr (o_fe_set_addr),
    .o_fe_set_data (o_fe_set_data),
    .o_fe_rb_addr  (o_fe_rb_addr),
    .i_fe_rb_data  (i_fe_rb_data)
  );

  always #50 i_ce_clk = ~i_ce_clk;

  // Elapsed clocks give the expected VITA time
  always @(posedge i_ce_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic write_reg(input int port, input set_addr_t addr, input set_data_t data);
    @(negedge i_ce_clk);
    i_set_stb       = '0;
    i_set_stb[port] = 1'b1;
    i_set_addr      = addr;
    i_set_data      = data;
    @(negedge i_ce_clk);
    i_set_stb = '0;
  endtask

  function automatic rb_data_t readback(input int port);
    return o_rb_data[RB_W*port +: RB_W];
  endfunction

  task automatic wait_resp(output resp_t word);
    int cyc;
    cyc = 0;
    do begin
      @(negedge i_ce_clk);
      cyc++;
      if (cyc > 100) begin
        $display("Timeout while waiting for a response word");
        stop_run();
      end
    end while (!o_resp_tvalid);
    word = o_resp_tdata;
  endtask

  // Strobes keep coming and nothing may show up
  task automatic expect_quiet(input int cycles);
    i_rx_stb = 1'b1;
    repeat (cycles) begin
      @(negedge i_ce_clk);
      i_rx = {lcg_next(), lcg_next()};
      check("o_resp_tvalid", o_resp_tvalid, 0);
      check("o_rx_tvalid", o_rx_tvalid, 0);
      check("o_run_rx", o_run_rx, 0);
    end
    i_rx_stb = 1'b0;
  endtask

  // Strobe every cycle and match n words against the strobed samples
  task automatic receive_burst(input int r, input int n, input vita_time_t not_before);
    sample_t exp_q[$];
    sample_t s;
    int      got;
    int      cyc;
    got = 0;
    cyc = 0;
    i_rx_tready[r] = 1'b1;
    forever begin
      if (o_rx_tvalid[r]) begin
        if (exp_q.size() == 0) begin
          $display("Receive word appeared without a strobed sample");
          stop_run();
        end
        check("o_rx_tdata", o_rx_tdata[SAMPLE_W*r +: SAMPLE_W], exp_q.pop_front());
        got++;
        check("o_rx_tlast", o_rx_tlast[r], got == n);
        check("rx word after command time", o_vita_time >= not_before, 1);
      end
      if (got == n) begin
        break;
      end
      if (cyc > 400) begin
        $display("Timeout while waiting for receive words");
        stop_run();
      end
      s = lcg_next();
      i_rx[SAMPLE_W*r +: SAMPLE_W] = s;
      i_rx_stb = 1'b1;
      if (o_run_rx[r]) begin
        check("rx strobe after command time", o_vita_time >= not_before, 1);
        exp_q.push_back(s);
      end
      @(negedge i_ce_clk);
      cyc++;
    end
    i_rx_stb = 1'b0;
    check("o_run_rx", o_run_rx[r], 0);
    check("samples left over", exp_q.size(), 0);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic time_loading();
    vita_time_t v;
    vita_time_t pre;
    int         c0;
    v = {32'h0000_0012, 32'h3456_789a};
    write_reg(1, SR_TIME_HI, v[63:32]);
    write_reg(1, SR_TIME_LO, v[31:0]);
    write_reg(1, SR_TIME_CTRL, 32'd1);
    c0 = cycle_cnt;
    check("o_rb_data[1]", readback(1), v);
    repeat (7) @(negedge i_ce_clk);
    check("o_rb_data[1]", readback(1), v + (cycle_cnt - c0));
    // Load armed for the next PPS
    v = {32'h0000_0abc, 32'h0000_0100};
    write_reg(1, SR_TIME_HI, v[63:32]);
    write_reg(1, SR_TIME_LO, v[31:0]);
    write_reg(1, SR_TIME_CTRL, 32'd2);
    pre = o_vita_time;
    c0  = cycle_cnt;
    repeat (5) @(negedge i_ce_clk);
    check("o_vita_time", o_vita_time, pre + (cycle_cnt - c0));
    i_pps = 1'b1;
    pre   = o_vita_time;
    @(negedge i_ce_clk);
    c0 = cycle_cnt;
    check("o_vita_time", o_vita_time, v);
    repeat (4) @(negedge i_ce_clk);
    check("o_rb_data[1]", readback(1), v + (cycle_cnt - c0));
    i_pps = 1'b0;
    write_reg(1, SR_RB_SEL, RB_VITA_LASTPPS);
    check("o_rb_data[1] lastpps", readback(1), pre);
    write_reg(1, SR_RB_SEL, RB_VITA_TIME);
  endtask

  task automatic untimed_rx();
    write_reg(1, SR_RX_NUM_SAMPS, 32'd8);
    write_reg(1, SR_RX_CMD, 32'd0);
    receive_burst(0, 8, '0);
    expect_quiet(6);
  endtask

  task automatic timed_and_late_rx();
    vita_time_t cmd;
    vita_time_t t_issue;
    resp_t      resp;
    cmd = o_vita_time + 64'd40;
    write_reg(1, SR_RX_NUM_SAMPS, 32'd4);
    write_reg(1, SR_RX_CMD_TIME_HI, cmd[63:32]);
    write_reg(1, SR_RX_CMD_TIME_LO, cmd[31:0]);
    write_reg(1, SR_RX_CMD, 32'd1);
    receive_burst(0, 4, cmd);
    expect_quiet(4);
    // Command time already behind the counter
    cmd = o_vita_time - 64'd5;
    write_reg(1, SR_RX_CMD_TIME_HI, cmd[63:32]);
    write_reg(1, SR_RX_CMD_TIME_LO, cmd[31:0]);
    t_issue = o_vita_time;
    write_reg(1, SR_RX_CMD, 32'd1);
    wait_resp(resp);
    check("o_resp_tdata index", resp[63:56], 8'd0);
    check("o_resp_tdata code", resp[55:48], RESP_LATE_CMD);
    check("late response time", (resp[47:0] >= t_issue[47:0]) &&
          (resp[47:0] <= o_vita_time[47:0]), 1);
    expect_quiet(10);
  endtask

  task automatic overrun_rx();
    resp_t resp;
    i_rx_tready[1] = 1'b0;
    i_rx_stb       = 1'b1;
    write_reg(2, SR_RX_NUM_SAMPS, 32'd8);
    write_reg(2, SR_RX_CMD, 32'd0);
    wait_resp(resp);
    check("o_resp_tdata index", resp[63:56], 8'd1);
    check("o_resp_tdata code", resp[55:48], RESP_OVERRUN);
    check("o_run_rx[1]", o_run_rx[1], 0);
    i_rx_stb       = 1'b0;
    i_rx_tready[1] = 1'b1;
    expect_quiet(6);
  endtask

  task automatic tx_underrun();
    logic [31:0] w;
    resp_t       first;
    resp_t       second;
    write_reg(1, SR_TX_CTRL, 32'd1);
    check("o_run_tx[0]", o_run_tx[0], 1);
    repeat (4) begin
      @(negedge i_ce_clk);
      w = lcg_next();
      i_tx_tdata[31:0] = w;
      i_tx_tvalid[0]   = 1'b1;
      i_tx_stb         = 1'b1;
      #10;
      check("o_tx_tready", o_tx_tready, 2'b01);
      @(negedge i_ce_clk);
      i_tx_stb       = 1'b0;
      i_tx_tvalid[0] = 1'b0;
      check("o_tx[0]", o_tx[31:0], w);
    end
    // Strobe with no word ready
    @(negedge i_ce_clk);
    i_tx_stb = 1'b1;
    @(negedge i_ce_clk);
    i_tx_stb = 1'b0;
    check("o_tx[0]", o_tx[31:0], 0);
    check("o_run_tx[0]", o_run_tx[0], 0);
    wait_resp(first);
    check("o_resp_tdata index", first[63:56], 8'd0);
    check("o_resp_tdata code", first[55:48], RESP_UNDERRUN);
    expect_quiet(4);
    // Both radios underrun into a stalled output
    i_resp_tready = 1'b0;
    write_reg(1, SR_TX_CTRL, 32'd1);
    write_reg(2, SR_TX_CTRL, 32'd1);
    @(negedge i_ce_clk);
    i_tx_stb = 1'b1;
    #10;
    check("o_tx_tready", o_tx_tready, 2'b11);
    @(negedge i_ce_clk);
    i_tx_stb = 1'b0;
    check("o_run_tx", o_run_tx, 0);
    check("o_tx", o_tx, 0);
    wait_resp(first);
    repeat (5) @(negedge i_ce_clk);
    check("o_resp_tvalid", o_resp_tvalid, 1);
    check("o_resp_tdata", o_resp_tdata, first);
    i_resp_tready = 1'b1;
    wait_resp(second);
    check("o_resp_tdata code", first[55:48], RESP_UNDERRUN);
    check("o_resp_tdata code", second[55:48], RESP_UNDERRUN);
    check("radio index sum", first[63:56] + second[63:56], 1);
    check("radio index difference", first[63:56] ^ second[63:56], 1);
    expect_quiet(6);
  endtask

  task automatic front_end_port();
    set_data_t  w;
    vita_time_t t0;
    int         c0;
    w = lcg_next();
    @(negedge i_ce_clk);
    i_set_stb  = 3'b001;
    i_set_addr = 8'h21;
    i_set_data = w;
    #10;
    check("o_fe_set_stb", o_fe_set_stb, 1);
    check("o_fe_set_addr", o_fe_set_addr, 8'h21);
    check("o_fe_set_data", o_fe_set_data, w);
    @(negedge i_ce_clk);
    i_set_stb = '0;
    #10;
    check("o_fe_set_stb", o_fe_set_stb, 0);
    write_reg(0, SR_FE_READBACK, 32'h0000_005a);
    check("o_fe_rb_addr", o_fe_rb_addr, 8'h5a);
    check("o_rb_data[0]", readback(0), i_fe_rb_data);
    // Radio registers and time ignore port 0
    t0 = o_vita_time;
    c0 = cycle_cnt;
    write_reg(0, SR_TIME_HI, 32'd0);
    write_reg(0, SR_TIME_LO, 32'd0);
    write_reg(0, SR_TIME_CTRL, 32'd1);
    write_reg(0, SR_RB_SEL, RB_RADIO_ID);
    write_reg(0, SR_TX_CTRL, 32'd1);
    check("o_vita_time", o_vita_time, t0 + (cycle_cnt - c0));
    check("o_rb_data[1]", readback(1), t0 + (cycle_cnt - c0));
    check("o_run_tx", o_run_tx, 0);
    write_reg(2, SR_RB_SEL, RB_RADIO_ID);
    check("o_rb_data[2]", readback(2), 1);
  endtask

  initial begin
    i_arst_n      = 1'b0;
    i_set_stb     = '0;
    i_set_addr    = '0;
    i_set_data    = '0;
    i_pps         = 1'b0;
    i_rx          = '0;
    i_rx_stb      = 1'b0;
    i_tx_stb      = 1'b0;
    i_rx_tready   = '1;
    i_tx_tdata    = '0;
    i_tx_tvalid   = '0;
    i_resp_tready = 1'b1;
    i_fe_rb_data  = {lcg_next(), lcg_next()};
    repeat (16) @(negedge i_ce_clk);
    check("o_vita_time", o_vita_time, 0);
    check("o_run_rx", o_run_rx, 0);
    check("o_run_tx", o_run_tx, 0);
    check("o_rx_tvalid", o_rx_tvalid, 0);
    check("o_resp_tvalid", o_resp_tvalid, 0);
    check("o_fe_set_stb", o_fe_set_stb, 0);
    i_arst_n = 1'b1;
    repeat (2) @(negedge i_ce_clk);

    time_loading();
    untimed_rx();
    timed_and_late_rx();
    overrun_rx();
    tx_underrun();
    front_end_port();

    repeat (2) @(negedge i_ce_clk);
    $display("Test OK");
    $finish;
  end

endmodule

// File: radio_block.f
radio_pkg.sv
settings_if.sv
timekeeper.sv
radio_rx_ctrl.sv
radio_core.sv
resp_mux.sv
radio_block.sv
tb_radio_block.sv

// File: Bender.yml
package:
  name: radio_block

sources:
  - radio_pkg.sv
  - settings_if.sv
  - timekeeper.sv
  - radio_rx_ctrl.sv
  - radio_core.sv
  - resp_mux.sv
  - radio_block.sv
  - target: test
    files:
      - tb_radio_block.sv
